// ==== project.f ====
design/rv_core_pkg.sv
design/inst_stream_if.sv
design/fetch_unit.sv
design/inst_queue.sv
design/inst_decoder.sv
design/register_file.sv
design/execute_unit.sv
design/rv_core_top.sv
dv/rv_core_tb.sv

// ==== Bender.yml ====
package:
  name: rv_core

sources:
  - design/rv_core_pkg.sv
  - design/inst_stream_if.sv
  - design/fetch_unit.sv
  - design/inst_queue.sv
  - design/inst_decoder.sv
  - design/register_file.sv
  - design/execute_unit.sv
  - design/rv_core_top.sv
  - target: test
    files:
      - dv/rv_core_tb.sv

// ==== dv/rv_core_tb.sv ====
`default_nettype none

module rv_core_tb import rv_core_pkg::*; ();

    localparam int PROG_LEN = 29;
    localparam logic [31:0] DATA_BASE = 32'h0001_0000;
    // 20 cycles per program word, plus reset and the quiet window after ebreak
    localparam int WATCHDOG_CYCLES = 3 + 20 * PROG_LEN + 50;

    typedef struct packed {
        logic [31:0] pc;
        logic we;
        logic [4:0] rd;
        logic [31:0] wdata;
        logic halt;
    } step_t;

    logic clk = 1'b0;
    logic reset;
    logic [31:0] imem_addr;
    logic [31:0] imem_rdata;
    logic [31:0] imem_off;
    logic [31:0] dmem_addr;
    logic dmem_we;
    logic [31:0] dmem_wdata;
    logic [3:0] dmem_wmask;
    logic [31:0] dmem_rdata;
    logic retire_valid;
    logic [31:0] retire_pc;
    logic retire_we;
    logic [4:0] retire_rd;
    logic [31:0] retire_wdata;
    logic halt;

    // program, data seen by the DUT, and the reference state
    logic [31:0] prog [PROG_LEN];
    logic [31:0] data_init [64];
    logic [31:0] dmem [64];
    logic [31:0] model_dmem [64];
    logic [31:0] model_regs [32];
    logic [31:0] model_pc;
    bit model_halted = 1'b0;
    integer seed;
    int errors = 0;
    int retire_count = 0;
    int expected_count = 0;

    rv_core_top DUT (
        .clk (clk),
        .reset (reset),
        .imem_addr (imem_addr),
        .imem_rdata (imem_rdata),
        .dmem_addr (dmem_addr),
        .dmem_we (dmem_we),
        .dmem_wdata (dmem_wdata),
        .dmem_wmask (dmem_wmask),
        .dmem_rdata (dmem_rdata),
        .retire_valid (retire_valid),
        .retire_pc (retire_pc),
        .retire_we (retire_we),
        .retire_rd (retire_rd),
        .retire_wdata (retire_wdata),
        .halt (halt)
    );

    always #10 clk = ~clk;

    // combinational memories
    // words past the program read as zero and decode as unknown
    assign imem_off = imem_addr - RESET_PC;
    assign imem_rdata = (imem_off < PROG_LEN * 4) ? prog[imem_off >> 2] : 32'h0;
    assign dmem_rdata = (dmem_addr[31:8] == DATA_BASE[31:8]) ? dmem[dmem_addr[7:2]] : ~dmem_addr;

    // byte-masked store at the rising edge
    always @(posedge clk) begin
        if (dmem_we) begin
            if (dmem_addr[31:8] != DATA_BASE[31:8]) begin
                errors++;
                $display("store to address %h lies outside the data memory", dmem_addr);
            end else begin
                for (int i = 0; i < 4; i++) begin
                    if (dmem_wmask[i]) begin
                        dmem[dmem_addr[7:2]][8*i +: 8] <= dmem_wdata[8*i +: 8];
                    end
                end
            end
        end
    end

    // instruction encoders
    function automatic logic [31:0] i_format(input logic [11:0] imm, input logic [4:0] rs1,
        input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] s_format(input logic [11:0] imm, input logic [4:0] rs2,
        input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] u_format(input logic [19:0] imm, input logic [4:0] rd,
        input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] j_format(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [31:0] add_word(input logic [4:0] rd, input logic [4:0] rs1,
        input logic [4:0] rs2);
        return {7'b0, rs2, rs1, 3'b000, rd, 7'b0110011};
    endfunction

    task automatic build_program();
        logic [31:0] rnd;
        logic [11:0] off0;
        logic [11:0] off1;
        logic [11:0] off2;
        logic [31:0] filler;
        seed = 32'h7b01_e46d;
        rnd = $random(seed);
        // three word offsets in separate regions of the data window
        off0 = {6'd0, rnd[5:2], 2'b00};
        off1 = {6'd0, rnd[9:6], 2'b00} + 12'd64;
        off2 = {6'd0, rnd[13:10], 2'b00} + 12'd128;
        filler = i_format(12'd1, 5'd13, 3'b000, 5'd13, 7'b0010011);
        prog[0] = u_format(DATA_BASE[31:12], 5'd10, 7'b0110111);
        prog[1] = i_format(12'($random(seed)), 5'd0, 3'b000, 5'd1, 7'b0010011);
        prog[2] = i_format(12'($random(seed)), 5'd1, 3'b000, 5'd2, 7'b0010011);
        prog[3] = add_word(5'd3, 5'd1, 5'd2);
        prog[4] = u_format(20'($random(seed)), 5'd4, 7'b0110111);
        prog[5] = u_format(20'($random(seed)), 5'd5, 7'b0010111);
        // write to x0 then read it back through add
        prog[6] = i_format(12'd5, 5'd1, 3'b000, 5'd0, 7'b0010011);
        prog[7] = add_word(5'd6, 5'd0, 5'd3);
        prog[8] = s_format(off0, 5'd3, 5'd10, 3'b010);
        prog[9] = i_format(off0, 5'd10, 3'b010, 5'd7, 7'b0000011);
        prog[10] = s_format(off1 + 12'd1, 5'd2, 5'd10, 3'b000);
        prog[11] = i_format(off1 + 12'd1, 5'd10, 3'b100, 5'd8, 7'b0000011);
        prog[12] = i_format(off1, 5'd10, 3'b010, 5'd9, 7'b0000011);
        prog[13] = i_format(off2 + 12'd3, 5'd10, 3'b100, 5'd11, 7'b0000011);
        // jal over four filler words flushes the queue
        prog[14] = j_format(21'd20, 5'd12);
        for (int i = 15; i < 19; i++) begin
            prog[i] = filler;
        end
        prog[19] = u_format(20'd0, 5'd14, 7'b0010111);
        prog[20] = i_format(12'd16, 5'd14, 3'b000, 5'd15, 7'b1100111);
        prog[21] = filler;
        prog[22] = filler;
        prog[23] = add_word(5'd17, 5'd15, 5'd12);
        // odd jalr target lands on word 26 once bit 0 is dropped
        prog[24] = i_format(12'd29, 5'd14, 3'b000, 5'd18, 7'b1100111);
        prog[25] = filler;
        // jal to pc plus 4 needs no redirect
        prog[26] = j_format(21'd4, 5'd20);
        prog[27] = i_format(off2, 5'd10, 3'b010, 5'd19, 7'b0000011);
        prog[28] = EBREAK_INST;
        for (int i = 0; i < 64; i++) begin
            data_init[i] = $random(seed);
            dmem[i] = data_init[i];
        end
        // top bit of the lbu byte set so zero extension shows
        data_init[off2[7:2]][31] = 1'b1;
        dmem[off2[7:2]] = data_init[off2[7:2]];
    endtask

    task automatic reset_model();
        model_pc = RESET_PC;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        for (int i = 0; i < 64; i++) begin
            model_dmem[i] = data_init[i];
        end
    endtask

    // one instruction on the model state by the ISA rules
    function automatic step_t ref_step();
        step_t s;
        logic [31:0] inst;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] imm_u;
        logic [31:0] imm_j;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] addr;
        logic [31:0] word;
        logic [31:0] next_pc;
        inst = prog[(model_pc - RESET_PC) >> 2];
        imm_i = {{20{inst[31]}}, inst[31:20]};
        imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
        imm_u = {inst[31:12], 12'b0};
        imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
        a = model_regs[inst[19:15]];
        b = model_regs[inst[24:20]];
        s = '0;
        s.pc = model_pc;
        s.rd = inst[11:7];
        next_pc = model_pc + 32'd4;
        if (inst == EBREAK_INST) begin
            s.halt = 1'b1;
        end else begin
            case (inst[6:0])
                7'b0110111: {s.we, s.wdata} = {1'b1, imm_u};
                7'b0010111: {s.we, s.wdata} = {1'b1, model_pc + imm_u};
                7'b1101111: begin
                    {s.we, s.wdata} = {1'b1, model_pc + 32'd4};
                    next_pc = model_pc + imm_j;
                end
                7'b1100111: begin
                    {s.we, s.wdata} = {1'b1, model_pc + 32'd4};
                    next_pc = (a + imm_i) & ~32'd1;
                end
                7'b0010011: {s.we, s.wdata} = {1'b1, a + imm_i};
                7'b0110011: {s.we, s.wdata} = {1'b1, a + b};
                7'b0000011: begin
                    addr = a + imm_i;
                    word = model_dmem[addr[7:2]];
                    s.we = 1'b1;
                    s.wdata = (inst[14:12] == 3'b010) ? word
                        : {24'b0, word[{addr[1:0], 3'b000} +: 8]};
                end
                7'b0100011: begin
                    addr = a + imm_s;
                    if (inst[14:12] == 3'b010) begin
                        model_dmem[addr[7:2]] = b;
                    end else begin
                        model_dmem[addr[7:2]][{addr[1:0], 3'b000} +: 8] = b[7:0];
                    end
                end
                default: s.we = 1'b0;
            endcase
        end
        // x0 writes vanish
        if (s.rd == 5'd0) begin
            s.we = 1'b0;
        end
        if (s.we) begin
            model_regs[s.rd] = s.wdata;
        end
        model_pc = next_pc;
        return s;
    endfunction

    // retire outputs are settled at the falling edge
    always @(negedge clk) begin : compare_retire
        step_t exp;
        if (!reset) begin
            if (retire_valid && model_halted) begin
                errors++;
                $display("FAILED at %0t: retire of pc %h after ebreak", $time, retire_pc);
            end else if (retire_valid) begin
                exp = ref_step();
                retire_count++;
                if (retire_count == 1 && retire_pc != RESET_PC) begin
                    errors++;
                    $display("FAILED at %0t: first retire pc %h", $time, retire_pc);
                end
                if (retire_pc != exp.pc) begin
                    errors++;
                    $display("FAILED at %0t: retire pc %h, expected %h", $time, retire_pc, exp.pc);
                end
                if (retire_we != exp.we) begin
                    errors++;
                    $display("FAILED at %0t: pc %h write enable %b, expected %b",
                        $time, exp.pc, retire_we, exp.we);
                end else if (exp.we && (retire_rd != exp.rd || retire_wdata != exp.wdata)) begin
                    errors++;
                    $display("FAILED at %0t: pc %h wrote x%0d=%h, expected x%0d=%h",
                        $time, exp.pc, retire_rd, retire_wdata, exp.rd, exp.wdata);
                end
                if (exp.halt) begin
                    model_halted = 1'b1;
                end
            end
            if (model_halted && !halt) begin
                errors++;
                $display("FAILED at %0t: halt low after ebreak", $time);
            end
            if (halt && !model_halted) begin
                errors++;
                $display("FAILED at %0t: halt high before ebreak", $time);
            end
            if (model_halted && dmem_we) begin
                errors++;
                $display("FAILED at %0t: store after ebreak", $time);
            end
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: no ebreak and quiet window within %0d cycles", WATCHDOG_CYCLES);
        $display("errors: %0d, retires: %0d of %0d", errors, retire_count, expected_count);
        $display("TEST FAIL");
        $finish;
    end

    initial begin : main
        step_t exp;
        bit done;
        reset = 1'b1;
        build_program();
        // dry run of the model for the retire count
        reset_model();
        done = 1'b0;
        while (!done && expected_count < 4 * PROG_LEN) begin
            exp = ref_step();
            expected_count++;
            done = exp.halt;
        end
        reset_model();
        repeat (3) @(negedge clk);
        reset = 1'b0;
        if (retire_valid || dmem_we || halt) begin
            errors++;
            $display("FAILED at %0t: retire_valid %b dmem_we %b halt %b after reset",
                $time, retire_valid, dmem_we, halt);
        end
        wait (model_halted);
        // comparator watches the quiet window
        repeat (50) @(negedge clk);
        if (retire_count != expected_count) begin
            errors++;
            $display("FAILED at %0t: %0d retires, expected %0d", $time, retire_count,
                expected_count);
        end
        $display("errors: %0d, retires: %0d of %0d", errors, retire_count, expected_count);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== design/rv_core_top.sv ====
`default_nettype none

module rv_core_top import rv_core_pkg::*; (
    input logic clk,
    input logic reset,
    output logic [XLEN-1:0] imem_addr,
    input logic [XLEN-1:0] imem_rdata,
    output logic [XLEN-1:0] dmem_addr,
    output logic dmem_we,
    output logic [XLEN-1:0] dmem_wdata,
    output logic [3:0] dmem_wmask,
    input logic [XLEN-1:0] dmem_rdata,
    output logic retire_valid,
    output logic [XLEN-1:0] retire_pc,
    output logic retire_we,
    output logic [4:0] retire_rd,
    output logic [XLEN-1:0] retire_wdata,
    output logic halt
);

    logic redirect;
    logic [XLEN-1:0] redirect_pc;

    // fetch to queue, queue head to execute
    inst_stream_if fetch_to_queue ();
    inst_stream_if queue_to_exec ();

    fetch_unit u_fetch (
        .clk (clk),
        .reset (reset),
        .halt (halt),
        .redirect (redirect),
        .redirect_pc (redirect_pc),
        .imem_addr (imem_addr),
        .imem_rdata (imem_rdata),
        .out (fetch_to_queue.producer)
    );

    inst_queue u_queue (
        .clk (clk),
        .reset (reset),
        .redirect (redirect),
        .in (fetch_to_queue.consumer),
        .out (queue_to_exec.producer)
    );

    execute_unit u_execute (
        .clk (clk),
        .reset (reset),
        .in (queue_to_exec.consumer),
        .redirect (redirect),
        .halt (halt),
        .redirect_pc (redirect_pc),
        .dmem_addr (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_we (dmem_we),
        .dmem_wmask (dmem_wmask),
        .dmem_rdata (dmem_rdata),
        .retire_valid (retire_valid),
        .retire_we (retire_we),
        .retire_rd (retire_rd),
        .retire_pc (retire_pc),
        .retire_wdata (retire_wdata)
    );

endmodule

`default_nettype wire

// ==== design/execute_unit.sv ====
`default_nettype none

module execute_unit import rv_core_pkg::*; (
    input logic clk,
    input logic reset,
    inst_stream_if.consumer in,
    output logic redirect,
    output logic halt,
    output logic [XLEN-1:0] redirect_pc,
    output logic [XLEN-1:0] dmem_addr,
    output logic [XLEN-1:0] dmem_wdata,
    output logic dmem_we,
    output logic [3:0] dmem_wmask,
    input logic [XLEN-1:0] dmem_rdata,
    output logic retire_valid,
    output logic retire_we,
    output logic [4:0] retire_rd,
    output logic [XLEN-1:0] retire_pc,
    output logic [XLEN-1:0] retire_wdata
);

    decoded_inst_t dec;
    logic [XLEN-1:0] rs1_val;
    logic [XLEN-1:0] rs2_val;
    logic fire;
    logic [XLEN-1:0] add_a;
    logic [XLEN-1:0] add_b;
    logic [XLEN-1:0] add_res;
    logic [XLEN-1:0] pc_plus4;
    logic [XLEN-1:0] jump_target;
    logic [XLEN-1:0] load_data;
    logic [XLEN-1:0] wb_data;
    logic [7:0] load_byte;
    logic is_jump;
    logic is_store;
    logic wb_en;

    inst_decoder u_decoder (
        .inst (in.inst),
        .dec (dec)
    );

    register_file u_regfile (
        .clk (clk),
        .we (wb_en),
        .waddr (dec.rd),
        .raddr1 (dec.rs1),
        .raddr2 (dec.rs2),
        .wdata (wb_data),
        .rdata1 (rs1_val),
        .rdata2 (rs2_val)
    );

    // one instruction per cycle, nothing after ebreak
    assign fire = in.valid && !halt;
    assign in.credit_return = fire;

    // shared adder
    // pc based for auipc and jal, rs2 only for add
    assign add_a = (dec.op == op_auipc || dec.op == op_jal) ? in.pc : rs1_val;
    assign add_b = (dec.op == op_add) ? rs2_val : dec.imm;
    assign add_res = add_a + add_b;
    assign pc_plus4 = in.pc + XLEN'(4);

    // jalr clears bit 0, a no-op for jal
    assign jump_target = {add_res[XLEN-1:1], 1'b0};
    assign is_jump = (dec.op == op_jal) || (dec.op == op_jalr);

    // fall-through target needs no redirect
    assign redirect = fire && is_jump && (jump_target != pc_plus4);
    assign redirect_pc = jump_target;

    // data memory
    // word-wide bus, low address bits pick the byte lane
    assign is_store = (dec.op == op_sw) || (dec.op == op_sb);
    assign dmem_addr = add_res;
    assign dmem_we = fire && is_store;
    assign dmem_wmask = (dec.op == op_sb) ? (4'b0001 << add_res[1:0]) : 4'b1111;
    assign dmem_wdata = (dec.op == op_sb) ? {4{rs2_val[7:0]}} : rs2_val;

    // lbu zero extends its lane
    assign load_byte = dmem_rdata[{add_res[1:0], 3'b000} +: 8];
    assign load_data = (dec.op == op_lbu) ? {24'b0, load_byte} : dmem_rdata;

    // writeback source
    always_comb begin
        case (dec.op)
            op_lw, op_lbu: wb_data = load_data;
            op_jal, op_jalr: wb_data = pc_plus4;
            op_lui: wb_data = dec.imm;
            default: wb_data = add_res;
        endcase
    end

    // stores, ebreak and unknown words write nothing
    always_comb begin
        case (dec.op)
            op_lui, op_auipc, op_jal, op_jalr, op_addi, op_add, op_lw, op_lbu: wb_en = fire;
            default: wb_en = 1'b0;
        endcase
    end

    // control state
    always_ff @(posedge clk) begin
        if (reset) begin
            retire_valid <= 1'b0;
            halt <= 1'b0;
        end else begin
            retire_valid <= fire;
            // sticky once ebreak retires
            if (fire && dec.op == op_ebreak) begin
                halt <= 1'b1;
            end
        end
    end

    // retire payload, qualified by retire_valid
    always_ff @(posedge clk) begin
        if (fire) begin
            retire_pc <= in.pc;
            // only real architectural writes, x0 excluded
            retire_we <= wb_en && (dec.rd != 5'd0);
            retire_rd <= dec.rd;
            retire_wdata <= wb_data;
        end
    end

    // once halted the core stays halted and never stores again
    a_halt_quiet: assert property (
        @(posedge clk) disable iff (reset)
        halt |=> halt && !dmem_we
    );

endmodule

`default_nettype wire

// ==== design/register_file.sv ====
`default_nettype none

module register_file import rv_core_pkg::*; (
    input logic clk,
    input logic we,
    input logic [4:0] waddr,
    input logic [4:0] raddr1,
    input logic [4:0] raddr2,
    input logic [XLEN-1:0] wdata,
    output logic [XLEN-1:0] rdata1,
    output logic [XLEN-1:0] rdata2
);

    logic [XLEN-1:0] regs [32];

    // x0 is never written
    always_ff @(posedge clk) begin
        if (we && (waddr != 5'd0)) begin
            regs[waddr] <= wdata;
        end
    end

    // asynchronous reads, x0 forced to zero
    assign rdata1 = (raddr1 == 5'd0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

// ==== design/inst_decoder.sv ====
`default_nettype none

module inst_decoder import rv_core_pkg::*; (
    input logic [XLEN-1:0] inst,
    output decoded_inst_t dec
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_j;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];

    // immediate formats, all sign extended from bit 31
    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        // register fields sit at fixed positions
        dec.rd = inst[11:7];
        dec.rs1 = inst[19:15];
        dec.rs2 = inst[24:20];
        dec.op = op_illegal;
        dec.imm = '0;

        if (inst == EBREAK_INST) begin
            dec.op = op_ebreak;
        end else begin
            case (opcode)
                OPC_LUI: begin
                    dec.op = op_lui;
                    dec.imm = imm_u;
                end
                OPC_AUIPC: begin
                    dec.op = op_auipc;
                    dec.imm = imm_u;
                end
                OPC_JAL: begin
                    dec.op = op_jal;
                    dec.imm = imm_j;
                end
                OPC_JALR: begin
                    if (funct3 == 3'b000) begin
                        dec.op = op_jalr;
                        dec.imm = imm_i;
                    end
                end
                OPC_OP_IMM: begin
                    if (funct3 == 3'b000) begin
                        dec.op = op_addi;
                        dec.imm = imm_i;
                    end
                end
                // funct7 not checked
                OPC_OP: begin
                    if (funct3 == 3'b000) begin
                        dec.op = op_add;
                    end
                end
                OPC_LOAD: begin
                    dec.imm = imm_i;
                    if (funct3 == 3'b010) begin
                        dec.op = op_lw;
                    end else if (funct3 == 3'b100) begin
                        dec.op = op_lbu;
                    end
                end
                OPC_STORE: begin
                    dec.imm = imm_s;
                    if (funct3 == 3'b010) begin
                        dec.op = op_sw;
                    end else if (funct3 == 3'b000) begin
                        dec.op = op_sb;
                    end
                end
                default: begin
                    dec.op = op_illegal;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== design/inst_queue.sv ====
`default_nettype none

module inst_queue import rv_core_pkg::*; (
    input logic clk,
    input logic reset,
    input logic redirect,
    inst_stream_if.consumer in,
    inst_stream_if.producer out
);

    logic [XLEN-1:0] pc_mem [QUEUE_DEPTH];
    logic [XLEN-1:0] inst_mem [QUEUE_DEPTH];
    logic [QPTR_W-1:0] rd_ptr;
    logic [QPTR_W-1:0] wr_ptr;
    logic [CREDIT_W-1:0] count;
    logic push;
    logic pop;

    // push of a redirect cycle belongs to the wrong path
    assign push = in.valid && !redirect;
    // pop strobe comes straight from execute
    assign pop = out.credit_return;

    // flushed entries hand back no credit
    assign in.credit_return = pop && !redirect;

    // head entry
    assign out.valid = (count != '0);
    assign out.pc = pc_mem[rd_ptr];
    assign out.inst = inst_mem[rd_ptr];

    // storage
    always_ff @(posedge clk) begin
        if (push) begin
            pc_mem[wr_ptr] <= in.pc;
            inst_mem[wr_ptr] <= in.inst;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || redirect) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == QPTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == QPTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CREDIT_W'(push) - CREDIT_W'(pop);
        end
    end

    // fetch credits must keep a slot free for every push
    a_no_push_full: assert property (
        @(posedge clk) disable iff (reset)
        push |-> count != CREDIT_W'(QUEUE_DEPTH)
    );

    // execute only pops a valid head
    a_no_pop_empty: assert property (
        @(posedge clk) disable iff (reset)
        pop |-> count != '0
    );

endmodule

`default_nettype wire

// ==== design/fetch_unit.sv ====
`default_nettype none

module fetch_unit import rv_core_pkg::*; (
    input logic clk,
    input logic reset,
    input logic halt,
    input logic redirect,
    input logic [XLEN-1:0] redirect_pc,
    output logic [XLEN-1:0] imem_addr,
    input logic [XLEN-1:0] imem_rdata,
    inst_stream_if.producer out
);

    logic [XLEN-1:0] pc;
    logic [CREDIT_W-1:0] credits;
    logic send;

    // instruction memory answers in the same cycle
    assign imem_addr = pc;

    // one word per cycle while a slot is guaranteed downstream
    assign send = (credits != '0) && !halt;

    assign out.valid = send;
    assign out.pc = pc;
    assign out.inst = imem_rdata;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= RESET_PC;
            credits <= CREDIT_W'(QUEUE_DEPTH);
        end else if (redirect) begin
            // queue is flushed this edge so every slot is free again
            pc <= redirect_pc;
            credits <= CREDIT_W'(QUEUE_DEPTH);
        end else begin
            // static prediction
            if (send) begin
                pc <= pc + XLEN'(4);
            end
            // spend and return may coincide
            credits <= credits - CREDIT_W'(send) + CREDIT_W'(out.credit_return);
        end
    end

    // returned credits never exceed the slots handed out
    a_credit_bound: assert property (
        @(posedge clk) disable iff (reset)
        credits <= CREDIT_W'(QUEUE_DEPTH)
    );

endmodule

`default_nettype wire

// ==== design/inst_stream_if.sv ====
`default_nettype none

// pc and instruction words moving downstream,
// one credit per freed slot moving back upstream
interface inst_stream_if import rv_core_pkg::*; ();

    logic valid;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] inst;
    logic credit_return;

    // sender of instruction words
    modport producer (
        output valid,
        output pc,
        output inst,
        input credit_return
    );

    // receiver, hands credits back
    modport consumer (
        input valid,
        input pc,
        input inst,
        output credit_return
    );

endinterface

`default_nettype wire

// ==== design/rv_core_pkg.sv ====
`default_nettype none

package rv_core_pkg;

    // data and address width
    localparam int XLEN = 32;

    // first fetch address out of reset
    localparam logic [XLEN-1:0] RESET_PC = 32'h8000_0000;

    // queue slots, also the credit count fetch starts with
    localparam int QUEUE_DEPTH = 4;
    // counter must hold the value QUEUE_DEPTH itself
    localparam int CREDIT_W = $clog2(QUEUE_DEPTH + 1);
    localparam int QPTR_W = $clog2(QUEUE_DEPTH);

    // full ebreak word, matched as a whole
    localparam logic [XLEN-1:0] EBREAK_INST = 32'h0010_0073;

    // major opcodes of the supported subset
    localparam logic [6:0] OPC_LUI = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC = 7'b0010111;
    localparam logic [6:0] OPC_JAL = 7'b1101111;
    localparam logic [6:0] OPC_JALR = 7'b1100111;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP = 7'b0110011;
    localparam logic [6:0] OPC_LOAD = 7'b0000011;
    localparam logic [6:0] OPC_STORE = 7'b0100011;

    typedef enum logic [3:0] {
        op_lui,
        op_auipc,
        op_jal,
        op_jalr,
        op_addi,
        op_add,
        op_lw,
        op_lbu,
        op_sw,
        op_sb,
        op_ebreak,
        op_illegal
    } inst_op_e;

    // decoder output consumed by execute
    typedef struct packed {
        inst_op_e op;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [XLEN-1:0] imm;
    } decoded_inst_t;

endpackage

`default_nettype wire
